// ==== lcd_params.svh ====
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// Line and frame geometry, in dots.
`define LCD_DOTS_PER_LINE 456
`define LCD_LINES         154
`define LCD_VISIBLE_LINES 144

// Mode boundaries within a visible line.
`define LCD_OAM_END  80
`define LCD_DRAW_END 252

// Panel strobe windows.
`define LCD_CP_START 92
`define LCD_ST_START 252
`define LCD_ST_LEN   4

// Register map on the AXI4-Lite port.
`define LCD_ADDR_LCDC 4'h0
`define LCD_ADDR_STAT 4'h4
`define LCD_ADDR_LY   4'h8
`define LCD_ADDR_LYC  4'hC

`endif

// ==== lcd_pkg.sv ====
package lcd_pkg;

	// Encoding matches the STAT mode field.
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} lcd_mode_e;

	typedef struct packed {
		logic       enable;
		logic       lyc_ie;
		logic       oam_ie;
		logic       vblank_ie;
		logic       hblank_ie;
		logic [7:0] lyc;
	} lcd_ctrl_t;

	typedef struct packed {
		logic [8:0] dot;
		logic [7:0] ly;
		lcd_mode_e  mode;
		logic       coincidence;
	} lcd_timing_t;

	// Master side of the register port.
	typedef struct packed {
		logic       awvalid;
		logic [3:0] awaddr;
		logic       wvalid;
		logic [7:0] wdata;
		logic       wstrb;
		logic       bready;
		logic       arvalid;
		logic [3:0] araddr;
		logic       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic       bvalid;
		logic [1:0] bresp;
		logic       arready;
		logic       rvalid;
		logic [7:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

// ==== lcd_regs.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_regs
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  axil_req_t   axil_req,
	input  lcd_timing_t timing,
	output axil_rsp_t   axil_rsp,
	output lcd_ctrl_t   ctrl
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic [7:0] lcdc;
	logic [3:0] stat_ie;
	logic [7:0] lyc;

	logic       bvalid;
	logic [1:0] bresp;
	logic       rvalid;
	logic [7:0] rdata;
	logic [1:0] rresp;

	logic       wr_go;
	logic       rd_go;
	logic       wr_known;
	logic [7:0] rd_data_d;
	logic [1:0] rd_resp_d;

	// AW and W are taken together, only with no response outstanding.
	assign wr_go = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign rd_go = axil_req.arvalid && !rvalid;

	always_comb begin
		case (axil_req.awaddr)
			`LCD_ADDR_LCDC,
			`LCD_ADDR_STAT,
			`LCD_ADDR_LY,
			`LCD_ADDR_LYC: wr_known = 1'b1;
			default:       wr_known = 1'b0;
		endcase
	end

	// LY is read only, so a write to it is answered but dropped.
	always_ff @(posedge clk) begin
		if (rst) begin
			lcdc    <= '0;
			stat_ie <= '0;
			lyc     <= '0;
		end else if (wr_go && axil_req.wstrb) begin
			case (axil_req.awaddr)
				`LCD_ADDR_LCDC: lcdc    <= axil_req.wdata;
				`LCD_ADDR_STAT: stat_ie <= axil_req.wdata[6:3];
				`LCD_ADDR_LYC:  lyc     <= axil_req.wdata;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
			bresp  <= RESP_OKAY;
		end else if (wr_go) begin
			bvalid <= 1'b1;
			bresp  <= wr_known ? RESP_OKAY : RESP_SLVERR;
		end else if (axil_req.bready) begin
			bvalid <= 1'b0;
		end
	end

	// STAT reads back bit 7 as one, with live coincidence and mode.
	always_comb begin
		rd_resp_d = RESP_OKAY;
		case (axil_req.araddr)
			`LCD_ADDR_LCDC: rd_data_d = lcdc;
			`LCD_ADDR_STAT: rd_data_d = {1'b1, stat_ie, timing.coincidence, timing.mode};
			`LCD_ADDR_LY:   rd_data_d = timing.ly;
			`LCD_ADDR_LYC:  rd_data_d = lyc;
			default: begin
				rd_data_d = '0;
				rd_resp_d = RESP_SLVERR;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= RESP_OKAY;
		end else if (rd_go) begin
			rvalid <= 1'b1;
			rdata  <= rd_data_d;
			rresp  <= rd_resp_d;
		end else if (axil_req.rready) begin
			rvalid <= 1'b0;
		end
	end

	assign axil_rsp.awready = wr_go;
	assign axil_rsp.wready  = wr_go;
	assign axil_rsp.bvalid  = bvalid;
	assign axil_rsp.bresp   = bresp;
	assign axil_rsp.arready = !rvalid;
	assign axil_rsp.rvalid  = rvalid;
	assign axil_rsp.rdata   = rdata;
	assign axil_rsp.rresp   = rresp;

	assign ctrl.enable    = lcdc[7];
	assign ctrl.lyc_ie    = stat_ie[3];
	assign ctrl.oam_ie    = stat_ie[2];
	assign ctrl.vblank_ie = stat_ie[1];
	assign ctrl.hblank_ie = stat_ie[0];
	assign ctrl.lyc       = lyc;

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !axil_req.bready |=> bvalid && $stable(bresp));

	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !axil_req.rready |=> rvalid && $stable(rdata));

endmodule

// ==== lcd_timing.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_timing
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  lcd_ctrl_t   ctrl,
	output lcd_timing_t timing
);

	logic [8:0] dot;
	logic [7:0] ly;
	logic [8:0] dot_out;
	logic [7:0] ly_out;
	logic       line_end;
	logic       frame_end;
	lcd_mode_e  mode;

	assign line_end  = dot == 9'(`LCD_DOTS_PER_LINE - 1);
	assign frame_end = ly == 8'(`LCD_LINES - 1);

	// Counters sit at zero while the LCD is off.
	always_ff @(posedge clk) begin
		if (rst || !ctrl.enable) begin
			dot <= '0;
			ly  <= '0;
		end else if (line_end) begin
			dot <= '0;
			ly  <= frame_end ? 8'd0 : ly + 8'd1;
		end else begin
			dot <= dot + 9'd1;
		end
	end

	// The counters clear a cycle late when LCDC bit 7 drops.
	assign dot_out = ctrl.enable ? dot : 9'd0;
	assign ly_out  = ctrl.enable ? ly : 8'd0;

	always_comb begin
		if (!ctrl.enable) begin
			mode = MODE_HBLANK;
		end else if (ly >= 8'(`LCD_VISIBLE_LINES)) begin
			mode = MODE_VBLANK;
		end else if (dot < 9'(`LCD_OAM_END)) begin
			mode = MODE_OAM;
		end else if (dot < 9'(`LCD_DRAW_END)) begin
			mode = MODE_DRAW;
		end else begin
			mode = MODE_HBLANK;
		end
	end

	assign timing.dot         = dot_out;
	assign timing.ly          = ly_out;
	assign timing.mode        = mode;
	assign timing.coincidence = ly_out == ctrl.lyc;

	a_dot_range: assert property (@(posedge clk) disable iff (rst)
		timing.dot < 9'(`LCD_DOTS_PER_LINE));

	a_ly_range: assert property (@(posedge clk) disable iff (rst)
		timing.ly < 8'(`LCD_LINES));

endmodule

// ==== lcd_control.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_control
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  lcd_ctrl_t   ctrl,
	input  lcd_timing_t timing,
	output logic        pin_cpl,
	output logic        pin_fr,
	output logic        pin_st,
	output logic        pin_s,
	output logic        pin_cp,
	output logic        irq_stat,
	output logic        irq_vblank
);

	logic visible;
	logic cp_win;
	logic st_win;
	logic cpl_win;
	logic s_win;
	logic frame_start;
	logic vblank_start;
	logic stat_src;
	logic stat_prev;

	assign visible = timing.ly < 8'(`LCD_VISIBLE_LINES);

	// Pixel clock runs over the last 160 dots of mode 3.
	assign cp_win = visible
		&& timing.dot >= 9'(`LCD_CP_START)
		&& timing.dot < 9'(`LCD_DRAW_END);

	assign st_win = visible
		&& timing.dot >= 9'(`LCD_ST_START)
		&& timing.dot < 9'(`LCD_ST_START + `LCD_ST_LEN);

	assign cpl_win      = timing.dot == 9'(`LCD_DOTS_PER_LINE - 1);
	assign s_win        = timing.ly == 8'd0;
	assign frame_start  = s_win && timing.dot == 9'd0;
	assign vblank_start = timing.ly == 8'(`LCD_VISIBLE_LINES) && timing.dot == 9'd0;

	// Combined STAT line, edge detected below.
	always_comb begin
		stat_src = 1'b0;
		if (ctrl.lyc_ie && timing.coincidence)
			stat_src = 1'b1;
		if (ctrl.oam_ie && timing.mode == MODE_OAM)
			stat_src = 1'b1;
		if (ctrl.vblank_ie && timing.mode == MODE_VBLANK)
			stat_src = 1'b1;
		if (ctrl.hblank_ie && timing.mode == MODE_HBLANK)
			stat_src = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst || !ctrl.enable) begin
			pin_cp     <= 1'b0;
			pin_st     <= 1'b0;
			pin_cpl    <= 1'b0;
			pin_s      <= 1'b0;
			pin_fr     <= 1'b0;
			irq_vblank <= 1'b0;
			irq_stat   <= 1'b0;
			stat_prev  <= 1'b0;
		end else begin
			pin_cp     <= cp_win;
			pin_st     <= st_win;
			pin_cpl    <= cpl_win;
			pin_s      <= s_win;
			irq_vblank <= vblank_start;
			stat_prev  <= stat_src;
			irq_stat   <= stat_src && !stat_prev;
			if (frame_start)
				pin_fr <= !pin_fr;
		end
	end

	a_cp_st_excl: assert property (@(posedge clk) disable iff (rst)
		!(pin_cp && pin_st));

endmodule

// ==== lcd_top.sv ====
`timescale 1ns/1ps

module lcd_top
	import lcd_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	output logic      pin_cpl,
	output logic      pin_fr,
	output logic      pin_st,
	output logic      pin_s,
	output logic      pin_cp,
	output logic      irq_stat,
	output logic      irq_vblank
);

	lcd_ctrl_t   ctrl;
	lcd_timing_t timing;

	lcd_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.axil_req (axil_req),
		.timing   (timing),
		.axil_rsp (axil_rsp),
		.ctrl     (ctrl)
	);

	lcd_timing u_timing (
		.clk    (clk),
		.rst    (rst),
		.ctrl   (ctrl),
		.timing (timing)
	);

	// Panel pins and interrupt requests.
	lcd_control u_control (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrl),
		.timing     (timing),
		.pin_cpl    (pin_cpl),
		.pin_fr     (pin_fr),
		.pin_st     (pin_st),
		.pin_s      (pin_s),
		.pin_cp     (pin_cp),
		.irq_stat   (irq_stat),
		.irq_vblank (irq_vblank)
	);

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = !clk;
	end

	// Reset spans the first ten rising edges.
	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

// ==== tb_lcd_top.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module tb_lcd_top
	import lcd_pkg::*;
();

	localparam int FRAME       = `LCD_DOTS_PER_LINE * `LCD_LINES;
	localparam int WATCHDOG_NS = (4 * FRAME + 2000) * 20;

	// Counter slots. The first seven follow the bit order of pins.
	typedef enum int {
		EV_CPL, EV_ST, EV_S, EV_IRQS, EV_IRQV, EV_FR, EV_CP, EV_CP_HI, EV_S_HI, EV_CYC
	} event_e;

	logic        clk;
	logic        rst;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	logic        pin_cpl;
	logic        pin_fr;
	logic        pin_st;
	logic        pin_s;
	logic        pin_cp;
	logic        irq_stat;
	logic        irq_vblank;
	logic [6:0]  pins;
	logic [6:0]  pins_q;
	int          cnt [10];
	int          snap [10];
	int          errors;
	logic [31:0] lfsr;
	string       ev_name [10] = '{"pin_cpl", "pin_st", "pin_s", "irq_stat", "irq_vblank",
		"pin_fr", "pin_cp", "pin_cp_high", "pin_s_high", "frame_cycles"};

	tb_clkgen u_clkgen (.*);
	lcd_top dut (.*);

	assign pins = {pin_cp, pin_fr, irq_vblank, irq_stat, pin_s, pin_st, pin_cpl};

	// Rising edges are counted, and both edges of the frame polarity.
	always @(negedge clk) begin
		for (int i = 0; i < 7; i++)
			if (i == EV_FR ? pins[i] != pins_q[i] : pins[i] && !pins_q[i])
				cnt[i]++;
		cnt[EV_CP_HI] += pin_cp;
		cnt[EV_S_HI] += pin_s;
		cnt[EV_CYC]++;
		pins_q = pins;
	end

	task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
	endtask

	task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report(name, got, exp);
	endtask

	task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp)
			report(name, got, exp);
	endtask

	task automatic check_mode(input string name, input lcd_mode_e got, input lcd_mode_e exp);
		if (got !== exp)
			report(name, got, exp);
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			report(name, got, exp);
	endtask

	// Fibonacci LFSR, taps 32, 22, 2 and 1.
	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic lcd_mode_e lcd_ref_mode(input int dot, input int line);
		if (line >= `LCD_VISIBLE_LINES)
			return MODE_VBLANK;
		if (dot < `LCD_OAM_END)
			return MODE_OAM;
		if (dot < `LCD_DRAW_END)
			return MODE_DRAW;
		return MODE_HBLANK;
	endfunction

	// Mode that follows m within a visible line, or at the start of the next one.
	function automatic lcd_mode_e next_mode(input lcd_mode_e m);
		case (m)
			MODE_OAM:  return lcd_ref_mode(`LCD_OAM_END, 0);
			MODE_DRAW: return lcd_ref_mode(`LCD_DRAW_END, 0);
			default:   return lcd_ref_mode(0, 0);
		endcase
	endfunction

	function automatic int frame_events(input int ev);
		case (ev)
			EV_CPL:   return `LCD_LINES;
			EV_ST,
			EV_CP:    return `LCD_VISIBLE_LINES;
			EV_CP_HI: return (`LCD_DRAW_END - `LCD_CP_START) * `LCD_VISIBLE_LINES;
			EV_S_HI:  return `LCD_DOTS_PER_LINE;
			EV_CYC:   return FRAME;
			default:  return 1;
		endcase
	endfunction

	task automatic wait_frame_start();
		int s0;
		s0 = cnt[EV_S];
		do @(posedge clk); while (cnt[EV_S] == s0);
	endtask

	task automatic axil_write(input logic [3:0] addr, input logic [7:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr  <= addr;
		axil_req.wvalid  <= 1'b1;
		axil_req.wdata   <= data;
		do @(negedge clk); while (!axil_rsp.awready);
		@(posedge clk);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		axil_req.bready  <= 1'b1;
		do @(negedge clk); while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		@(posedge clk);
		axil_req.bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [7:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr  <= addr;
		do @(negedge clk); while (!axil_rsp.arready);
		@(posedge clk);
		axil_req.arvalid <= 1'b0;
		axil_req.rready  <= 1'b1;
		do @(negedge clk); while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clk);
		axil_req.rready <= 1'b0;
	endtask

	initial begin
		logic [1:0] resp;
		logic [7:0] data;
		logic [7:0] ly_a;
		logic [7:0] ly_b;
		logic [7:0] lyc;
		lcd_mode_e  mode;
		lcd_mode_e  prev;
		int         err0;
		int         irqs;
		int         steps;
		foreach (cnt[i])
			cnt[i] = 0;
		pins_q = '0;
		errors = 0;
		lfsr = 32'hae18_657a;
		axil_req = '0;
		axil_req.wstrb = 1'b1;
		do @(posedge clk); while (rst);

		// Offset 0x2 lies inside the 4-bit address space but decodes to no register.
		err0 = errors;
		axil_write(`LCD_ADDR_LCDC, 8'h11, resp);
		check_resp("bresp", resp, 2'b00);
		axil_read(`LCD_ADDR_LCDC, data, resp);
		check_data("lcdc", data, 8'h11);
		check_resp("rresp", resp, 2'b00);
		lyc = lfsr_bits(8);
		axil_write(`LCD_ADDR_LYC, lyc, resp);
		axil_read(`LCD_ADDR_LYC, data, resp);
		check_data("lyc", data, lyc);
		axil_write(`LCD_ADDR_LY, 8'h5a, resp);
		check_resp("bresp_ly", resp, 2'b00);
		axil_read(`LCD_ADDR_LY, data, resp);
		check_data("ly", data, 8'h00);
		axil_read(`LCD_ADDR_LCDC, data, resp);
		check_data("lcdc_after_ly_write", data, 8'h11);
		axil_read(`LCD_ADDR_LYC, data, resp);
		check_data("lyc_after_ly_write", data, lyc);
		axil_write(4'h2, 8'hff, resp);
		check_resp("bresp_unmapped", resp, 2'b10);
		axil_read(4'h2, data, resp);
		check_resp("rresp_unmapped", resp, 2'b10);
		$display("register access: %0d errors", errors - err0);

		err0 = errors;
		axil_read(`LCD_ADDR_LY, data, resp);
		check_data("ly_off", data, 8'h00);
		axil_read(`LCD_ADDR_STAT, data, resp);
		check_mode("stat_mode_off", lcd_mode_e'(data[1:0]), MODE_HBLANK);
		snap = cnt;
		repeat (FRAME) @(posedge clk);
		for (int i = 0; i < 7; i++)
			check_count(ev_name[i], cnt[i] - snap[i], 0);
		$display("lcd disabled: %0d errors", errors - err0);

		err0 = errors;
		axil_write(`LCD_ADDR_LCDC, 8'h91, resp);
		wait_frame_start();
		snap = cnt;
		wait_frame_start();
		for (int i = 0; i < 10; i++)
			if (i != EV_IRQS)
				check_count(ev_name[i], cnt[i] - snap[i], frame_events(i));
		$display("frame structure: %0d errors", errors - err0);

		// A LY, STAT, LY triple is judged only when both LY reads agree.
		err0 = errors;
		prev = MODE_VBLANK;
		steps = 0;
		do begin
			axil_read(`LCD_ADDR_LY, ly_a, resp);
			axil_read(`LCD_ADDR_STAT, data, resp);
			axil_read(`LCD_ADDR_LY, ly_b, resp);
			mode = lcd_mode_e'(data[1:0]);
			if (ly_b >= `LCD_LINES)
				report("ly_range", ly_b, `LCD_LINES - 1);
			if (ly_a == ly_b && ly_a >= `LCD_VISIBLE_LINES) begin
				check_mode("stat_mode_vblank", mode, lcd_ref_mode(0, ly_a));
			end else if (ly_a == ly_b && (mode != prev || prev == MODE_VBLANK)) begin
				check_mode("stat_mode_order", mode, next_mode(prev));
				prev = mode;
				steps++;
			end
		end while (ly_b != 8'(`LCD_VISIBLE_LINES + 2));
		// Every visible line passes through three modes.
		check_count("mode_steps", steps, 3 * `LCD_VISIBLE_LINES);
		$display("mode sequence: %0d errors", errors - err0);

		err0 = errors;
		lyc = 8'(lfsr_bits(8) % `LCD_LINES);
		axil_write(`LCD_ADDR_LYC, lyc, resp);
		axil_write(`LCD_ADDR_STAT, 8'h40, resp);
		wait_frame_start();
		snap = cnt;
		irqs = cnt[EV_IRQS];
		do begin
			@(posedge clk);
			if (cnt[EV_IRQS] != irqs) begin
				irqs = cnt[EV_IRQS];
				// The pulse follows dot 0 of line LYC, so both reads land in that line.
				axil_read(`LCD_ADDR_STAT, data, resp);
				axil_read(`LCD_ADDR_LY, ly_a, resp);
				check_data("stat_coincidence", data & 8'h04, 8'h04);
				check_data("ly_at_irq", ly_a, lyc);
			end
		end while (cnt[EV_S] == snap[EV_S]);
		check_count("irq_stat", cnt[EV_IRQS] - snap[EV_IRQS], frame_events(EV_IRQS));
		check_count("irq_vblank", cnt[EV_IRQV] - snap[EV_IRQV], frame_events(EV_IRQV));
		$display("interrupts (lyc 0x%h): %0d errors", lyc, errors - err0);

		$display("5 tests done, %0d errors", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, a handshake or frame never completed",
			WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
lcd_pkg.sv
lcd_regs.sv
lcd_timing.sv
lcd_control.sv
lcd_top.sv
tb_clkgen.sv
tb_lcd_top.sv

// ==== Bender.yml ====
package:
  name: lcd_ppu

sources:
  - include_dirs:
      - .
    files:
      - lcd_pkg.sv
      - lcd_regs.sv
      - lcd_timing.sv
      - lcd_control.sv
      - lcd_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_lcd_top.sv
